//--- tb_clk_gen.sv
// testbench clock source
// free running clock, 4 ns period
`timescale 1ns/1ns

module tb_clk_gen
(
    output logic clk_o
);

    // half period of 2 ns
    initial
    begin
        clk_o = 1'b0;
        forever
            #2 clk_o = ~clk_o;
    end

endmodule

//--- tb_vga_rx.sv
// testbench for the vga receive path
// plays vga lines from a record file, acts as the dma engine, checks words and pulses
`timescale 1ns/1ns
`include "vga_rx_macros.svh"

module tb_vga_rx;

    localparam int MAX_REC = 64;

    logic                       clk_i;
    logic                       rst_i;
    logic                       vsync_i;
    logic                       hsync_i;
    logic                       de_i;
    vga_rx_video_pkg::pixel_t   pix_i;
    logic                       rd_i;
    vga_rx_dma_pkg::word_t      rd_data_o;
    logic                       ovf_o;
    logic                       line_thresh_o;
    logic                       dma_en_i;
    logic                       dma_active_i;
    logic                       dma_req_o;
    logic                       dma_clr_o;
    logic                       dma_done_o;
    logic                       fifo_empty;
    vga_rx_dma_pkg::fifo_lvl_t  fifo_level;

    // records: opcode nibble over a 32 bit argument
    logic [35:0]                recs [MAX_REC];
    vga_rx_dma_pkg::word_t      exp_q [$];
    int                         n_rec = 0;
    int                         val_errs = 0;
    int                         misc_errs = 0;
    // set when a frame closes with words still expected
    logic                       frame_flag = 1'b0;
    logic [15:0]                lfsr_q = 16'd58961;

    tb_clk_gen u_clk_gen
    (
        .clk_o (clk_i)
    );

    vga_rx_top u_vga_rx_top
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .vsync_i       (vsync_i),
        .hsync_i       (hsync_i),
        .de_i          (de_i),
        .pix_i         (pix_i),
        .rd_i          (rd_i),
        .rd_data_o     (rd_data_o),
        .ovf_o         (ovf_o),
        .line_thresh_o (line_thresh_o),
        .dma_en_i      (dma_en_i),
        .dma_active_i  (dma_active_i),
        .dma_req_o     (dma_req_o),
        .dma_clr_o     (dma_clr_o),
        .dma_done_o    (dma_done_o)
    );

    // fifo status is not on the top ports
    assign fifo_empty = u_vga_rx_top.stat.empty;
    assign fifo_level = u_vga_rx_top.stat.level;

    // ------------------------------
    // helpers
    // ------------------------------

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        logic        fb;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = (v << 1) | fb;
        end
        return v;
    endfunction

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
            val_errs++;
        end
    endtask

    // pixels base, base+1, ... then de low with an hsync pulse
    task automatic drive_line(input int n, input logic [7:0] base);
        int gap;
        for (int i = 0; i < n; i++)
        begin
            de_i  = 1'b1;
            pix_i = vga_rx_video_pkg::pixel_t'(base + i);
            next_cycle();
        end
        de_i    = 1'b0;
        hsync_i = 1'b1;
        next_cycle();
        hsync_i = 1'b0;
        gap = take_bits(2);
        repeat (gap) next_cycle();
    endtask

    task automatic pulse_vsync();
        int gap;
        if (exp_q.size() != 0)
            frame_flag = 1'b1;
        vsync_i = 1'b1;
        next_cycle();
        next_cycle();
        vsync_i = 1'b0;
        gap = 1 + take_bits(2);
        repeat (gap) next_cycle();
    endtask

    task automatic run_record(input logic [35:0] rec);
        logic [3:0]  op;
        logic [31:0] arg;
        op  = rec[35:32];
        arg = rec[31:0];
        case (op)
            4'h1: drive_line(arg[15:8], arg[7:0]);
            4'h2: pulse_vsync();
            4'h3: exp_q.push_back(arg);
            4'h4: dma_en_i = arg[0];
            4'h5:
            begin
                repeat (3) next_cycle();
                check_val("line_thresh_o", line_thresh_o, arg[0]);
            end
            4'h6:
            begin
                while (exp_q.size() != 0)
                    next_cycle();
            end
            4'h7:
            begin
                repeat (3) next_cycle();
                check_val("ovf_o", ovf_o, arg[0]);
            end
            default:
            begin
                assert (1'b0)
                else
                begin
                    $display("unknown record opcode %h in the stimulus file", op);
                    misc_errs++;
                end
            end
        endcase
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial
    begin : main
        vsync_i      = 1'b0;
        hsync_i      = 1'b0;
        de_i         = 1'b0;
        pix_i        = '0;
        rd_i         = 1'b0;
        dma_en_i     = 1'b0;
        dma_active_i = 1'b0;
        rst_i        = 1'b1;
        $readmemh("tb_vga_rx_input.txt", recs);
        // record count sizes the watchdog, end record included
        while (n_rec < MAX_REC - 1 && recs[n_rec][35:32] !== 4'h0)
            n_rec++;
        n_rec++;
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        // reset state
        check_val("dma_req_o", dma_req_o, 0);
        check_val("dma_clr_o", dma_clr_o, 0);
        check_val("dma_done_o", dma_done_o, 0);
        check_val("ovf_o", ovf_o, 0);
        check_val("fifo empty", fifo_empty, 1);
        for (int i = 0; i < MAX_REC; i++)
        begin
            if (recs[i][35:32] === 4'h0)
                break;
            run_record(recs[i]);
        end
        // let the engine finish its done pulse
        repeat (10) next_cycle();
        $display("errors: %0d value, %0d other", val_errs, misc_errs);
        if (val_errs + misc_errs == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // ------------------------------
    // dma engine model
    // ------------------------------
    initial
    begin : dma_engine
        int wait_cyc;
        @(negedge rst_i);
        forever
        begin
            next_cycle();
            if (dma_req_o)
            begin
                assert (fifo_level >= `VGA_RX_BURST || frame_flag)
                else
                begin
                    $display("dma_req_o raised with neither a burst nor a finished frame");
                    misc_errs++;
                end
                frame_flag = 1'b0;
                wait_cyc = take_bits(3);
                repeat (wait_cyc) next_cycle();
                dma_active_i = 1'b1;
                // clear two edges after active, request gone by the third
                for (int k = 0; k < 3; k++)
                begin
                    next_cycle();
                    check_val("dma_clr_o", dma_clr_o, k == 1);
                end
                check_val("dma_req_o", dma_req_o, 0);
                while (!fifo_empty)
                begin
                    assert (exp_q.size() != 0)
                    else
                    begin
                        $display("word read from the FIFO with none expected");
                        misc_errs++;
                    end
                    if (exp_q.size() != 0)
                        check_val("rd_data_o", rd_data_o, exp_q.pop_front());
                    rd_i = 1'b1;
                    next_cycle();
                end
                rd_i = 1'b0;
                dma_active_i = 1'b0;
                for (int k = 0; k < 3; k++)
                begin
                    next_cycle();
                    check_val("dma_done_o", dma_done_o, k == 1);
                end
            end
        end
    end

    // request must not rise off a disabled edge
    initial
    begin : req_monitor
        logic req_prev;
        logic en_edge;
        req_prev = 1'b0;
        @(negedge rst_i);
        forever
        begin
            @(posedge clk_i);
            en_edge = dma_en_i;
            #1;
            assert (!(dma_req_o && !req_prev && !en_edge))
            else
            begin
                $display("dma_req_o rose at %0t ns while dma_en_i was low", $time);
                misc_errs++;
            end
            req_prev = dma_req_o;
        end
    end

    initial
    begin : watchdog
        wait (n_rec > 0);
        #(n_rec * 200);
        $display("timeout: run did not finish within %0d ns", n_rec * 200);
        $display("tests failed");
        $finish;
    end

endmodule

//--- tb_vga_rx_input.txt
// one record per line: opcode digit, then 8 hex digits of argument
// 1 pixel line [15:8] count [7:0] first pixel, 2 vsync, 3 expected word, 4 dma enable
// 5 line_thresh check, 6 wait for drain, 7 ovf check, 0 end
400000000
200000000
100000A10
313121110
317161514
300001918
500000000
100000620
323222120
300002524
500000001
400000001
600000000
200000000
500000000
100000330
300323130
200000000
600000000
400000000
100004840
700000001
000000000

//--- vga_rx.f
+incdir+.
vga_rx_video_pkg.sv
vga_rx_dma_pkg.sv
vga_rx_sync_decode.sv
vga_rx_pixel_pack.sv
vga_rx_fifo.sv
vga_rx_dma_ctrl.sv
vga_rx_top.sv
tb_clk_gen.sv
tb_vga_rx.sv

//--- vga_rx_dma_ctrl.sv
// dma request controller
// raises the request on a burst or a finished frame, syncs dma active
// and pulses clear on its rise and done on its fall
`timescale 1ns/1ns
`include "vga_rx_macros.svh"

module vga_rx_dma_ctrl
(
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  vga_rx_dma_pkg::fifo_stat_t stat_i,
    input  logic                       frame_done_i,
    input  logic                       dma_en_i,
    input  logic                       dma_active_i,
    output logic                       dma_req_o,
    output logic                       dma_clr_o,
    output logic                       dma_done_o
);

    // active synchronizer chain
    logic act_1ff;
    logic act_2ff;
    logic act_3ff;

    // frame ended with words left behind
    logic pend_q;

    logic burst_rdy;
    logic req_set;

    // ------------------------------
    // request condition
    // ------------------------------
    assign burst_rdy = (stat_i.level >= vga_rx_dma_pkg::fifo_lvl_t'(`VGA_RX_BURST));
    assign req_set   = dma_en_i & ~dma_req_o & ~act_2ff & (burst_rdy | pend_q);

    // edges of the synced level
    assign dma_clr_o  = act_2ff & ~act_3ff;
    assign dma_done_o = act_3ff & ~act_2ff;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            act_1ff   <= 1'b0;
            act_2ff   <= 1'b0;
            act_3ff   <= 1'b0;
            pend_q    <= 1'b0;
            dma_req_o <= 1'b0;
        end
        else
        begin
            act_1ff <= dma_active_i;
            act_2ff <= act_1ff;
            act_3ff <= act_2ff;

            // a fresh frame end wins over the clear
            if (frame_done_i && !stat_i.empty)
                pend_q <= 1'b1;
            else if (dma_clr_o)
                pend_q <= 1'b0;

            // engine answered, drop the request
            if (act_2ff)
                dma_req_o <= 1'b0;
            else if (req_set)
                dma_req_o <= 1'b1;
        end
    end

endmodule

//--- vga_rx_dma_pkg.sv
// fifo and dma side types for the vga receive path
// packed word, fifo level and the fifo status bundle
`include "vga_rx_macros.svh"

package vga_rx_dma_pkg;

    // one fifo word, four pixels wide
    typedef logic [`VGA_RX_PIX_W*`VGA_RX_PIX_PER_WORD-1:0] word_t;

    // fifo occupancy, needs to hold 0 up to the full depth
    typedef logic [$clog2(`VGA_RX_FIFO_DEPTH+1)-1:0] fifo_lvl_t;

    // fifo status seen by the dma controller
    typedef struct packed
    {
        logic      empty;
        logic      full;
        fifo_lvl_t level;
    } fifo_stat_t;

endpackage

//--- vga_rx_fifo.sv
// word fifo, first word fall through
// circular buffer with level count, sticky overflow on write when full
`timescale 1ns/1ns
`include "vga_rx_macros.svh"

module vga_rx_fifo
(
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       wr_i,
    input  vga_rx_dma_pkg::word_t      wr_data_i,
    input  logic                       rd_i,
    output vga_rx_dma_pkg::word_t      rd_data_o,
    output vga_rx_dma_pkg::fifo_stat_t stat_o,
    output logic                       ovf_o
);

    localparam int PTR_W = $clog2(`VGA_RX_FIFO_DEPTH);

    // storage
    vga_rx_dma_pkg::word_t mem [`VGA_RX_FIFO_DEPTH];

    logic [PTR_W-1:0]         wr_ptr_q;
    logic [PTR_W-1:0]         rd_ptr_q;
    vga_rx_dma_pkg::fifo_lvl_t level_q;

    logic do_wr;
    logic do_rd;

    // ------------------------------
    // status
    // ------------------------------
    assign stat_o.level = level_q;
    assign stat_o.empty = (level_q == '0);
    assign stat_o.full  = (level_q == vga_rx_dma_pkg::fifo_lvl_t'(`VGA_RX_FIFO_DEPTH));

    // full drops writes, empty ignores reads
    assign do_wr = wr_i & ~stat_o.full;
    assign do_rd = rd_i & ~stat_o.empty;

    // head word always visible
    assign rd_data_o = mem[rd_ptr_q];

    // pointers, level, overflow
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
            ovf_o    <= 1'b0;
        end
        else
        begin
            // depth is a power of two so pointers wrap by themselves
            if (do_wr)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_rd)
                rd_ptr_q <= rd_ptr_q + 1'b1;

            if (do_wr && !do_rd)
                level_q <= level_q + 1'b1;
            else if (do_rd && !do_wr)
                level_q <= level_q - 1'b1;

            // held until reset
            if (wr_i && stat_o.full)
                ovf_o <= 1'b1;
        end
    end

    // memory write port
    always_ff @(posedge clk_i)
    begin
        if (do_wr)
            mem[wr_ptr_q] <= wr_data_i;
    end

endmodule

//--- vga_rx_macros.svh
// vga receive path sizing macros
// pixel, word, fifo and dma burst dimensions shared by all blocks
`ifndef VGA_RX_MACROS_SVH
`define VGA_RX_MACROS_SVH

// ------------------------------
// video side
// ------------------------------

// bits per incoming pixel
`define VGA_RX_PIX_W 8

// pixels packed into one fifo word
`define VGA_RX_PIX_PER_WORD 4

// line count that raises the line threshold flag
`define VGA_RX_LINE_THRESH 2

// ------------------------------
// fifo and dma side
// ------------------------------

// word fifo depth, power of two
`define VGA_RX_FIFO_DEPTH 16

// words in fifo that trigger a dma request
`define VGA_RX_BURST 4

`endif

//--- vga_rx_pixel_pack.sv
// pixel packer
// collects pixels into fifo words with the first pixel in the low byte
// and flushes zero padded partial words at line end
`timescale 1ns/1ns
`include "vga_rx_macros.svh"

module vga_rx_pixel_pack
(
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  vga_rx_video_pkg::video_evt_t evt_i,
    output logic                         wr_o,
    output vga_rx_dma_pkg::word_t        wr_data_o,
    output logic                         frame_done_o
);

    localparam int CNT_W = $clog2(`VGA_RX_PIX_PER_WORD);

    // byte slot for the next pixel, wrapping at pixels per word
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_nxt;

    // word under construction
    vga_rx_dma_pkg::word_t acc_q;
    vga_rx_dma_pkg::word_t acc_nxt;

    logic word_full;
    logic flush;

    // ------------------------------
    // merge incoming pixel
    // ------------------------------
    always_comb
    begin
        acc_nxt = acc_q;
        if (evt_i.pix_vld)
            acc_nxt[cnt_q*`VGA_RX_PIX_W +: `VGA_RX_PIX_W] = evt_i.pix;
    end

    assign cnt_nxt   = cnt_q + CNT_W'(evt_i.pix_vld);
    assign word_full = evt_i.pix_vld & (cnt_q == CNT_W'(`VGA_RX_PIX_PER_WORD - 1));

    // partial word only goes out if it holds a pixel
    assign flush = word_full | (evt_i.line_end & (cnt_nxt != '0));

    // control
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            cnt_q        <= '0;
            wr_o         <= 1'b0;
            frame_done_o <= 1'b0;
        end
        else
        begin
            wr_o <= flush;
            // frame done trails frame end by one cycle
            frame_done_o <= evt_i.frame_end;
            if (flush)
                cnt_q <= '0;
            else
                cnt_q <= cnt_nxt;
        end
    end

    // payload
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            // first word after reset starts from zero bytes too
            wr_data_o <= '0;
            acc_q     <= '0;
        end
        else if (flush)
        begin
            wr_data_o <= acc_nxt;
            // cleared so unused bytes of a short word are zero
            acc_q     <= '0;
        end
        else
        begin
            acc_q <= acc_nxt;
        end
    end

endmodule

//--- vga_rx_sync_decode.sv
// vga sync decoder
// turns sampled vsync/hsync/de into pixel strobes, line and frame events
// and keeps the per-frame line count and threshold flag
`timescale 1ns/1ns
`include "vga_rx_macros.svh"

module vga_rx_sync_decode
(
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        vsync_i,
    input  logic                        hsync_i,
    input  logic                        de_i,
    input  vga_rx_video_pkg::pixel_t    pix_i,
    output vga_rx_video_pkg::video_evt_t evt_o,
    output vga_rx_video_pkg::line_cnt_t line_cnt_o,
    output logic                        line_thresh_o
);

    vga_rx_video_pkg::decode_state_e state_q;
    vga_rx_video_pkg::decode_state_e state_nxt;
    vga_rx_video_pkg::line_cnt_t     line_cnt_nxt;

    // previous sync levels for edge detect
    logic vsync_q;
    logic hsync_q;

    logic vs_rise;
    logic hs_rise;
    logic in_frame;
    logic line_end;
    logic frame_end;

    // ------------------------------
    // edges and events
    // ------------------------------
    assign vs_rise   = vsync_i & ~vsync_q;
    assign hs_rise   = hsync_i & ~hsync_q;
    assign in_frame  = (state_q != vga_rx_video_pkg::IDLE);

    // line closes on de fall, hsync pulse also closes it
    assign line_end  = (state_q == vga_rx_video_pkg::LINE) & (~de_i | hs_rise);

    // first vsync only opens a frame, later ones close it
    assign frame_end = vs_rise & in_frame;

    assign line_cnt_nxt = line_cnt_o + 1'b1;

    // next state
    always_comb
    begin
        state_nxt = state_q;
        case (state_q)
            vga_rx_video_pkg::IDLE:
            begin
                if (vs_rise)
                    state_nxt = vga_rx_video_pkg::FRAME;
            end
            vga_rx_video_pkg::FRAME:
            begin
                if (vs_rise)
                    state_nxt = vga_rx_video_pkg::FRAME;
                else if (de_i)
                    state_nxt = vga_rx_video_pkg::LINE;
            end
            vga_rx_video_pkg::LINE:
            begin
                if (vs_rise || line_end)
                    state_nxt = vga_rx_video_pkg::FRAME;
            end
            default:
                state_nxt = vga_rx_video_pkg::IDLE;
        endcase
    end

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q       <= vga_rx_video_pkg::IDLE;
            vsync_q       <= 1'b0;
            hsync_q       <= 1'b0;
            evt_o         <= '0;
            line_cnt_o    <= '0;
            line_thresh_o <= 1'b0;
        end
        else
        begin
            state_q <= state_nxt;
            vsync_q <= vsync_i;
            hsync_q <= hsync_i;

            // one cycle from sample to event
            evt_o.pix_vld   <= de_i & in_frame;
            evt_o.pix       <= pix_i;
            evt_o.line_end  <= line_end;
            evt_o.frame_end <= frame_end;

            // new frame restarts count and drops flag
            if (vs_rise)
            begin
                line_cnt_o    <= '0;
                line_thresh_o <= 1'b0;
            end
            else if (line_end)
            begin
                line_cnt_o <= line_cnt_nxt;
                if (line_cnt_nxt >= `VGA_RX_LINE_THRESH)
                    line_thresh_o <= 1'b1;
            end
        end
    end

endmodule

//--- vga_rx_top.sv
// vga receive path top
// sync decode, pixel packing, word fifo and dma request control
`timescale 1ns/1ns

module vga_rx_top
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    // video input
    input  logic                     vsync_i,
    input  logic                     hsync_i,
    input  logic                     de_i,
    input  vga_rx_video_pkg::pixel_t pix_i,
    // word read port
    input  logic                     rd_i,
    output vga_rx_dma_pkg::word_t    rd_data_o,
    output logic                     ovf_o,
    output logic                     line_thresh_o,
    // dma handoff
    input  logic                     dma_en_i,
    input  logic                     dma_active_i,
    output logic                     dma_req_o,
    output logic                     dma_clr_o,
    output logic                     dma_done_o
);

    vga_rx_video_pkg::video_evt_t evt;
    vga_rx_dma_pkg::word_t        wr_data;
    vga_rx_dma_pkg::fifo_stat_t   stat;
    logic                         wr;
    logic                         frame_done;

    // ------------------------------
    // decode
    // ------------------------------
    vga_rx_sync_decode u_sync_decode
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .vsync_i       (vsync_i),
        .hsync_i       (hsync_i),
        .de_i          (de_i),
        .pix_i         (pix_i),
        .evt_o         (evt),
        // line count stays internal, only the flag leaves
        .line_cnt_o    (),
        .line_thresh_o (line_thresh_o)
    );

    // pack into words
    vga_rx_pixel_pack u_pixel_pack
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .evt_i        (evt),
        .wr_o         (wr),
        .wr_data_o    (wr_data),
        .frame_done_o (frame_done)
    );

    // word buffer
    vga_rx_fifo u_fifo
    (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_i      (wr),
        .wr_data_i (wr_data),
        .rd_i      (rd_i),
        .rd_data_o (rd_data_o),
        .stat_o    (stat),
        .ovf_o     (ovf_o)
    );

    // dma request
    vga_rx_dma_ctrl u_dma_ctrl
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stat_i       (stat),
        .frame_done_i (frame_done),
        .dma_en_i     (dma_en_i),
        .dma_active_i (dma_active_i),
        .dma_req_o    (dma_req_o),
        .dma_clr_o    (dma_clr_o),
        .dma_done_o   (dma_done_o)
    );

endmodule

//--- vga_rx_video_pkg.sv
// video side types for the vga receive path
// pixel and line types, decode fsm states and the decode event bundle
`include "vga_rx_macros.svh"

package vga_rx_video_pkg;

    // one sampled pixel
    typedef logic [`VGA_RX_PIX_W-1:0] pixel_t;

    // lines seen in the current frame
    typedef logic [9:0] line_cnt_t;

    // decode fsm
    // idle waits for the first vsync, frame sits between lines,
    // line is inside an active line
    typedef enum logic [1:0]
    {
        IDLE  = 2'd0,
        FRAME = 2'd1,
        LINE  = 2'd2
    } decode_state_e;

    // decode to pack events, all single cycle
    typedef struct packed
    {
        // pixel strobe and its data
        logic   pix_vld;
        pixel_t pix;
        // line and frame boundaries
        logic   line_end;
        logic   frame_end;
    } video_evt_t;

endpackage
